// File: core_if_pkg.sv
package core_if_pkg;

	// Plain data word, also carries the IOSR value
	typedef logic [31:0] word_t;

	// Byte address toward the data memory
	typedef logic [31:0] addr_t;

	// Page directory table base
	typedef logic [31:0] pdt_t;

	// Task id of the requesting thread
	typedef logic [13:0] tid_t;

	// Access size: 00 byte, 01 halfword, 10 word, 11 none
	typedef logic [1:0] order_t;

	// MMU mode of the access
	typedef logic [1:0] mmumod_t;

	// External interrupt number
	typedef logic [5:0] irq_num_t;

	// Memory request credits, holds up to MEM_CREDITS
	typedef logic [2:0] credit_t;

	// One data memory request, 115 bits
	typedef struct packed {
		order_t		order;
		logic		rw;		// 1 = read, 0 = write
		tid_t		tid;
		mmumod_t	mmumod;
		pdt_t		pdt;
		addr_t		addr;
		word_t		data;
	} data_req_t;

	// Request queue geometry
	localparam int REQ_QUEUE_DEPTH = 4;
	localparam int REQ_QUEUE_PTR_W = 2;

	// Credits granted by the memory side after reset
	localparam credit_t MEM_CREDITS = 3'd4;

	// Consecutive high samples needed before IOSR is trusted
	localparam int IOSR_STABLE_EDGES = 4;

	// IOSR qualifier states
	typedef enum logic [2:0] {
		IOSR_WAIT,
		IOSR_CAN1,
		IOSR_CAN2,
		IOSR_GET,
		IOSR_HELD
	} iosr_state_t;

	// Interrupt handshake states
	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_OFFER,
		IRQ_ACK
	} irq_state_t;

endpackage

// File: iosr_capture.sv
module iosr_capture import core_if_pkg::*; (
	input	logic	iCORE_CLOCK,
	input	logic	inRESET,
	input	logic	sysinfo_iosr_valid,
	input	word_t	sysinfo_iosr,
	output	logic	iosr_valid,
	output	word_t	iosr
);

	iosr_state_t	state;
	word_t			iosr_word;

	// Qualifier walk, any low sample before the last step restarts it
	always_ff @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IOSR_WAIT;
		end else begin
			case (state)
				IOSR_WAIT: begin
					// First high sample
					if (sysinfo_iosr_valid) begin
						state <= IOSR_CAN1;
					end
				end
				IOSR_CAN1: begin
					state <= sysinfo_iosr_valid ? IOSR_CAN2 : IOSR_WAIT;
				end
				IOSR_CAN2: begin
					state <= sysinfo_iosr_valid ? IOSR_GET : IOSR_WAIT;
				end
				IOSR_GET: begin
					// Fourth high sample, word is taken on this edge
					state <= sysinfo_iosr_valid ? IOSR_HELD : IOSR_WAIT;
				end
				IOSR_HELD: begin
					// Frozen until reset
					state <= IOSR_HELD;
				end
				default: begin
					state <= IOSR_WAIT;
				end
			endcase
		end
	end

	// Word register, loaded once on the qualifying edge
	always_ff @(posedge iCORE_CLOCK) begin
		if ((state == IOSR_GET) && sysinfo_iosr_valid) begin
			iosr_word <= sysinfo_iosr;
		end
	end

	assign iosr_valid = (state == IOSR_HELD);
	assign iosr = iosr_word;

	// Once published, the IOSR view never moves again
	a_iosr_frozen: assert property (
		@(posedge iCORE_CLOCK) disable iff (!inRESET)
		iosr_valid |=> iosr_valid && $stable(iosr)
	);

endmodule

// File: credit_counter.sv
module credit_counter import core_if_pkg::*; (
	input	logic	iCORE_CLOCK,
	input	logic	inRESET,
	input	logic	spend,
	input	logic	give_back,
	output	logic	credit_avail
);

	credit_t	count;

	// Starts full, memory side grants all credits at reset
	always_ff @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= MEM_CREDITS;
		end else begin
			case ({spend, give_back})
				2'b10: begin
					// Issue only
					count <= count - 1'b1;
				end
				2'b01: begin
					// Return only
					count <= count + 1'b1;
				end
				default: begin
					// Idle, or issue and return cancel out
					count <= count;
				end
			endcase
		end
	end

	// Credit usable from the cycle after its return
	assign credit_avail = (count != '0);

	// Issue logic must never spend a credit it does not hold
	a_no_spend_at_zero: assert property (
		@(posedge iCORE_CLOCK) disable iff (!inRESET)
		spend |-> (count != '0)
	);

	// Memory side never returns more than it granted
	a_count_bounded: assert property (
		@(posedge iCORE_CLOCK) disable iff (!inRESET)
		count <= MEM_CREDITS
	);

endmodule

// File: req_queue.sv
module req_queue import core_if_pkg::*; (
	input	logic		iCORE_CLOCK,
	input	logic		inRESET,
	input	logic		push,
	input	data_req_t	push_data,
	input	logic		pop,
	output	data_req_t	head,
	output	logic		full,
	output	logic		empty
);

	// Entry storage
	data_req_t						mem [REQ_QUEUE_DEPTH];

	// Circular pointers, wrap on their own at a power-of-two depth
	logic [REQ_QUEUE_PTR_W-1:0]		wr_ptr;
	logic [REQ_QUEUE_PTR_W-1:0]		rd_ptr;

	// One extra bit so a full queue is distinct from empty
	logic [REQ_QUEUE_PTR_W:0]		count;

	logic							wr_en;
	logic							rd_en;

	// Guarded strobes
	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// Pointer and occupancy bookkeeping
	always_ff @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Entry write
	always_ff @(posedge iCORE_CLOCK) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// Oldest entry shown straight from storage
	assign head = mem[rd_ptr];

	// Status flags
	assign full  = (count == (REQ_QUEUE_PTR_W + 1)'(REQ_QUEUE_DEPTH));
	assign empty = (count == '0);

	// Core must honour the lock, a push into a full queue is lost
	a_no_push_full: assert property (
		@(posedge iCORE_CLOCK) disable iff (!inRESET)
		push |-> !full
	);

	// Issue logic only pops real entries
	a_no_pop_empty: assert property (
		@(posedge iCORE_CLOCK) disable iff (!inRESET)
		pop |-> !empty
	);

endmodule

// File: irq_handshake.sv
module irq_handshake import core_if_pkg::*; (
	input	logic		iCORE_CLOCK,
	input	logic		inRESET,
	input	logic		interrupt_valid,
	input	irq_num_t	interrupt_num,
	input	logic		core_irq_ack,
	output	logic		interrupt_ack,
	output	logic		core_irq_valid,
	output	irq_num_t	core_irq_num
);

	irq_state_t		state;
	irq_num_t		num;

	// One interrupt in flight at a time
	always_ff @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IRQ_IDLE;
		end else begin
			case (state)
				IRQ_IDLE: begin
					// Source request taken
					if (interrupt_valid) begin
						state <= IRQ_OFFER;
					end
				end
				IRQ_OFFER: begin
					// Held toward the core until it answers
					if (core_irq_ack) begin
						state <= IRQ_ACK;
					end
				end
				IRQ_ACK: begin
					// Single acknowledge cycle to the source
					state <= IRQ_IDLE;
				end
				default: begin
					state <= IRQ_IDLE;
				end
			endcase
		end
	end

	// Number latch, only in idle so a held request is not resampled
	always_ff @(posedge iCORE_CLOCK) begin
		if ((state == IRQ_IDLE) && interrupt_valid) begin
			num <= interrupt_num;
		end
	end

	// Outputs decoded from state
	assign core_irq_valid = (state == IRQ_OFFER);
	assign interrupt_ack  = (state == IRQ_ACK);
	assign core_irq_num   = num;

	// Core only answers an interrupt that is on offer
	a_ack_while_offered: assert property (
		@(posedge iCORE_CLOCK) disable iff (!inRESET)
		core_irq_ack |-> core_irq_valid
	);

endmodule

// File: core_if.sv
module core_if import core_if_pkg::*; (
	input	logic		iCORE_CLOCK,
	input	logic		inRESET,
	// Core data request
	input	logic		data_req_push,
	input	data_req_t	data_req,
	output	logic		data_req_lock,
	// Memory request channel
	output	logic		mem_req_valid,
	output	data_req_t	mem_req,
	input	logic		mem_credit_return,
	// System information
	input	logic		sysinfo_iosr_valid,
	input	word_t		sysinfo_iosr,
	output	logic		iosr_valid,
	output	word_t		iosr,
	// Interrupt source
	input	logic		interrupt_valid,
	input	irq_num_t	interrupt_num,
	output	logic		interrupt_ack,
	// Interrupt to the core
	output	logic		core_irq_valid,
	output	irq_num_t	core_irq_num,
	input	logic		core_irq_ack
);

	logic	queue_empty;
	logic	credit_avail;
	logic	issue;

	// IOSR qualify and hold
	iosr_capture u_iosr_capture (
		.iCORE_CLOCK		(iCORE_CLOCK),
		.inRESET			(inRESET),
		.sysinfo_iosr_valid	(sysinfo_iosr_valid),
		.sysinfo_iosr		(sysinfo_iosr),
		.iosr_valid			(iosr_valid),
		.iosr				(iosr)
	);

	// Issue whenever an entry waits and a credit is held
	assign issue = !queue_empty && credit_avail;

	// Core to memory request queue, full flag locks the core
	req_queue u_req_queue (
		.iCORE_CLOCK	(iCORE_CLOCK),
		.inRESET		(inRESET),
		.push			(data_req_push),
		.push_data		(data_req),
		.pop			(issue),
		.head			(mem_req),
		.full			(data_req_lock),
		.empty			(queue_empty)
	);

	// Memory side credits
	credit_counter u_credit_counter (
		.iCORE_CLOCK	(iCORE_CLOCK),
		.inRESET		(inRESET),
		.spend			(issue),
		.give_back		(mem_credit_return),
		.credit_avail	(credit_avail)
	);

	// Each valid cycle pops one entry, no ready
	assign mem_req_valid = issue;

	// Interrupt source to core and back
	irq_handshake u_irq_handshake (
		.iCORE_CLOCK		(iCORE_CLOCK),
		.inRESET			(inRESET),
		.interrupt_valid	(interrupt_valid),
		.interrupt_num		(interrupt_num),
		.core_irq_ack		(core_irq_ack),
		.interrupt_ack		(interrupt_ack),
		.core_irq_valid		(core_irq_valid),
		.core_irq_num		(core_irq_num)
	);

endmodule

// File: tb_core_if.sv
module tb_core_if import core_if_pkg::*; ();

	localparam int WAIT_LIMIT = 200;
	localparam int SEED = 32'h39d2e1c8;

	// Wait conditions
	localparam int W_LOCK = 0;
	localparam int W_DRAINED = 1;
	localparam int W_IOSR = 2;
	localparam int W_IRQ_OFFER = 3;
	localparam int W_IRQ_ACK = 4;

	logic		iCORE_CLOCK = 1'b0;
	logic		inRESET;
	logic		data_req_push;
	data_req_t	data_req;
	logic		mem_credit_return = 1'b0;
	logic		sysinfo_iosr_valid;
	word_t		sysinfo_iosr;
	logic		interrupt_valid;
	irq_num_t	interrupt_num;
	logic		core_irq_ack;
	logic		data_req_lock;
	logic		mem_req_valid;
	data_req_t	mem_req;
	logic		iosr_valid;
	word_t		iosr;
	logic		interrupt_ack;
	logic		core_irq_valid;
	irq_num_t	core_irq_num;

	// Reference model state
	data_req_t	sb[$];
	data_req_t	exp_head;
	int			sb_count;
	int			credits;
	int			outstanding;
	int			run_len;
	logic		model_held;
	word_t		exp_iosr;
	irq_num_t	exp_irq_num;

	logic		returns_on = 1'b0;
	int			ret_wait = 0;
	int			errors = 0;
	int			tests = 0;

	core_if u_core_if (.*);

	always #5 iCORE_CLOCK = ~iCORE_CLOCK;

	// Request scoreboard and credit model with pop before push to keep order
	always @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			sb.delete();
			sb_count <= 0;
			exp_head <= '0;
			credits <= MEM_CREDITS;
			outstanding <= 0;
		end else begin
			if (mem_req_valid && (sb.size() > 0)) begin
				void'(sb.pop_front());
			end
			if (data_req_push && (sb_count < REQ_QUEUE_DEPTH)) begin
				sb.push_back(data_req);
			end
			credits <= credits - (mem_req_valid ? 1 : 0) + (mem_credit_return ? 1 : 0);
			outstanding <= outstanding + (mem_req_valid ? 1 : 0) - (mem_credit_return ? 1 : 0);
			sb_count <= sb.size();
			exp_head <= (sb.size() > 0) ? sb[0] : '0;
		end
	end

	// IOSR qualifier model
	always @(posedge iCORE_CLOCK or negedge inRESET) begin
		if (!inRESET) begin
			run_len <= 0;
			model_held <= 1'b0;
			exp_iosr <= '0;
		end else if (!model_held) begin
			if (!sysinfo_iosr_valid) begin
				run_len <= 0;
			end else if (run_len == IOSR_STABLE_EDGES - 1) begin
				model_held <= 1'b1;
				exp_iosr <= sysinfo_iosr;
			end else begin
				run_len <= run_len + 1;
			end
		end
	end

	// Memory side returns one credit per pulse after a random gap
	always @(posedge iCORE_CLOCK) begin
		#1;
		if (mem_credit_return || !returns_on || (outstanding == 0)) begin
			mem_credit_return = 1'b0;
		end else if (ret_wait != 0) begin
			ret_wait = ret_wait - 1;
		end else begin
			mem_credit_return = 1'b1;
			ret_wait = $urandom_range(3, 0);
		end
	end

	a_reset_state: assert property (@(posedge iCORE_CLOCK)
		(!inRESET || $past(!inRESET)) |->
		({mem_req_valid, data_req_lock, iosr_valid, core_irq_valid, interrupt_ack} == 5'b0))
	else begin
		errors++;
		$display("error reset_state: expected %b, actual %b", 5'b0,
			{mem_req_valid, data_req_lock, iosr_valid, core_irq_valid, interrupt_ack});
	end

	a_iosr_flag: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		iosr_valid == model_held)
	else begin
		errors++;
		$display("error iosr_qualify: expected %b, actual %b", model_held, iosr_valid);
	end

	a_iosr_word: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		iosr_valid |-> (iosr == exp_iosr))
	else begin
		errors++;
		$display("error iosr_qualify: expected %h, actual %h", exp_iosr, iosr);
	end

	a_req_order: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		mem_req_valid |-> (mem_req == exp_head))
	else begin
		errors++;
		$display("error req_order: expected %h, actual %h", exp_head, mem_req);
	end

	// Issue exactly when an entry waits and a credit is held
	a_issue_rule: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		mem_req_valid == ((credits > 0) && (sb_count > 0)))
	else begin
		errors++;
		$display("error credit_limit: expected %b, actual %b",
			(credits > 0) && (sb_count > 0), mem_req_valid);
	end

	a_lock_rule: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		data_req_lock == (sb_count == REQ_QUEUE_DEPTH))
	else begin
		errors++;
		$display("error credit_limit: expected %b, actual %b",
			sb_count == REQ_QUEUE_DEPTH, data_req_lock);
	end

	a_irq_num: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		core_irq_valid |-> (core_irq_num == exp_irq_num))
	else begin
		errors++;
		$display("error irq_round_trip: expected %h, actual %h", exp_irq_num, core_irq_num);
	end

	// Ack back on the next cycle with the offer withdrawn
	a_irq_ack_next: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		core_irq_ack |=> (interrupt_ack && !core_irq_valid))
	else begin
		errors++;
		$display("error irq_round_trip: expected %b, actual %b", 2'b10,
			{interrupt_ack, core_irq_valid});
	end

	a_irq_ack_single: assert property (@(posedge iCORE_CLOCK) disable iff (!inRESET)
		interrupt_ack |-> $past(core_irq_ack))
	else begin
		errors++;
		$display("error irq_round_trip: expected %b, actual %b", 1'b0, interrupt_ack);
	end

	function automatic data_req_t random_req();
		data_req_t	r;
		word_t		bits;
		bits = $urandom;
		r.order = bits[1:0];
		r.rw = bits[2];
		r.mmumod = bits[4:3];
		r.tid = bits[18:5];
		r.pdt = $urandom;
		r.addr = $urandom;
		r.data = $urandom;
		return r;
	endfunction

	function automatic logic condition_met(input int sel);
		case (sel)
			W_LOCK: return data_req_lock;
			W_DRAINED: return (sb_count == 0) && (outstanding == 0);
			W_IOSR: return iosr_valid;
			W_IRQ_OFFER: return core_irq_valid;
			W_IRQ_ACK: return interrupt_ack;
			default: return 1'b0;
		endcase
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge iCORE_CLOCK);
			#1;
		end
	endtask

	task automatic drive_iosr(input logic valid, input word_t word);
		sysinfo_iosr_valid = valid;
		sysinfo_iosr = word;
		idle_cycles(1);
	endtask

	task automatic report_test(input string name, input int base);
		tests++;
		$display("test %s done, %0d errors", name, errors - base);
	endtask

	task automatic end_run();
		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	task automatic wait_for(input int sel, input string what);
		int cycles;
		cycles = 0;
		while (!condition_met(sel) && (cycles <= WAIT_LIMIT)) begin
			idle_cycles(1);
			cycles++;
		end
		if (cycles > WAIT_LIMIT) begin
			errors++;
			$display("timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
		end
	endtask

	initial begin
		int			base;
		int			pushes;
		word_t		bits;
		void'($urandom(SEED));
		inRESET = 1'b1;
		data_req_push = 1'b0;
		data_req = '0;
		sysinfo_iosr_valid = 1'b0;
		sysinfo_iosr = '0;
		interrupt_valid = 1'b0;
		interrupt_num = '0;
		core_irq_ack = 1'b0;
		exp_irq_num = '0;
		#1;
		inRESET = 1'b0;
		base = errors;
		repeat (16) @(posedge iCORE_CLOCK);
		#1;
		inRESET = 1'b1;
		idle_cycles(3);
		report_test("reset_state", base);

		// Short runs first and then a qualifying run with a moving word
		base = errors;
		for (int i = 0; i < IOSR_STABLE_EDGES - 1; i++) begin
			drive_iosr(1'b1, $urandom);
		end
		drive_iosr(1'b0, $urandom);
		drive_iosr(1'b1, $urandom);
		drive_iosr(1'b0, $urandom);
		for (int i = 0; i < IOSR_STABLE_EDGES + 2; i++) begin
			drive_iosr(1'b1, $urandom);
		end
		wait_for(W_IOSR, "iosr_valid rise");
		// Input keeps moving after capture
		for (int i = 0; i < 6; i++) begin
			bits = $urandom;
			drive_iosr(bits[0], bits);
		end
		report_test("iosr_qualify", base);

		// Returns withheld until the queue locks
		base = errors;
		pushes = 0;
		while (!data_req_lock && (pushes < 3 * REQ_QUEUE_DEPTH)) begin
			data_req = random_req();
			data_req_push = 1'b1;
			idle_cycles(1);
			pushes++;
		end
		data_req_push = 1'b0;
		wait_for(W_LOCK, "data_req_lock with credits spent");
		idle_cycles(4);
		returns_on = 1'b1;
		wait_for(W_DRAINED, "request queue drain");
		report_test("credit_limit", base);

		// Random traffic with random credit returns
		base = errors;
		for (int i = 0; i < 40; i++) begin
			bits = $urandom;
			data_req = random_req();
			data_req_push = !data_req_lock && bits[0];
			idle_cycles(1);
		end
		data_req_push = 1'b0;
		wait_for(W_DRAINED, "request queue drain");
		report_test("req_order", base);

		base = errors;
		for (int i = 0; i < 4; i++) begin
			bits = $urandom;
			interrupt_num = bits[5:0];
			exp_irq_num = bits[5:0];
			interrupt_valid = 1'b1;
			wait_for(W_IRQ_OFFER, "core_irq_valid");
			idle_cycles(int'(bits[9:8]));
			core_irq_ack = 1'b1;
			idle_cycles(1);
			core_irq_ack = 1'b0;
			wait_for(W_IRQ_ACK, "interrupt_ack");
			interrupt_valid = 1'b0;
			idle_cycles(2);
		end
		report_test("irq_round_trip", base);

		end_run();
	end

endmodule

// File: sources.f
core_if_pkg.sv
iosr_capture.sv
credit_counter.sv
req_queue.sv
irq_handshake.sv
core_if.sv
tb_core_if.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core_if testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_core_if
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" \
	--Mdir obj_dir -o "sim_$TOP" -f sources.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./obj_dir/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
	exit 1
fi

exit 0
